// ==== verilog/regFilePkg.sv ====
`default_nettype none

package regFilePkg;

    localparam int DataWidth = 16;
    localparam int RegAddrWidth = 4;
    localparam int MemAddrWidth = 16;

    typedef logic [RegAddrWidth-1:0] regAddrT;
    typedef logic [DataWidth-1:0] dataT;
    typedef logic [MemAddrWidth-1:0] memAddrT;

    typedef struct packed {
        regAddrT addr;
        logic    en;
    } readReqT;

    // Shared by execution writes and load write-backs
    typedef struct packed {
        regAddrT addr;
        logic    en;
        dataT    data;
    } regWriteT;

    typedef struct packed {
        logic    valid;
        regAddrT dest;
        memAddrT addr;
    } loadReqT;

    // APB requester side
    typedef struct packed {
        logic    psel;
        logic    penable;
        logic    pwrite;
        memAddrT paddr;
        dataT    pwdata;
    } apbReqT;

    // APB completer side
    typedef struct packed {
        dataT prdata;
        logic pready;
        logic pslverr;
    } apbRspT;

endpackage

`default_nettype wire

// ==== verilog/registerCell.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerCell (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clkEn,
    input  logic             writeEn,
    input  regFilePkg::dataT dataIn,
    input  logic             memWriteEn,
    input  regFilePkg::dataT memDataIn,
    input  logic             dirtySet,
    output regFilePkg::dataT dataOut,
    output logic             dirtyOut
);
    import regFilePkg::*;

    dataT dataReg;
    logic dirtyReg;

    // Write-back wins over an execution write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dataReg <= '0;
        end else if (clkEn) begin
            if (memWriteEn) begin
                dataReg <= memDataIn;
            end else if (writeEn) begin
                dataReg <= dataIn;
            end
        end
    end

    // A new load on this register keeps it dirty
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dirtyReg <= 1'b0;
        end else if (clkEn) begin
            if (dirtySet) begin
                dirtyReg <= 1'b1;
            end else if (memWriteEn) begin
                dirtyReg <= 1'b0;
            end
        end
    end

    assign dataOut = dataReg;
    assign dirtyOut = dirtyReg;

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
    parameter int RegisterCount = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clkEn,
    input  regFilePkg::readReqT  readA,
    input  regFilePkg::readReqT  readB,
    input  regFilePkg::regWriteT exWrite,
    input  regFilePkg::regWriteT memWrite,
    input  logic                 dirtySet,
    input  regFilePkg::regAddrT  dirtyAddr,
    output regFilePkg::dataT     readDataA,
    output regFilePkg::dataT     readDataB,
    output logic                 regsSync,
    output logic                 stall
);
    import regFilePkg::*;

    logic [RegisterCount-1:0] exDecode;
    logic [RegisterCount-1:0] memDecode;
    logic [RegisterCount-1:0] dirtyDecode;

    dataT                     cellData [RegisterCount];
    logic [RegisterCount-1:0] dirtyVec;

    logic       stallA;
    logic       stallB;
    logic       stallRaw;
    logic [1:0] stallLatch;

    // One-hot decoders, already qualified by their enables
    always_comb begin
        exDecode = '0;
        exDecode[exWrite.addr] = exWrite.en;
    end

    always_comb begin
        memDecode = '0;
        memDecode[memWrite.addr] = memWrite.en;
    end

    always_comb begin
        dirtyDecode = '0;
        dirtyDecode[dirtyAddr] = dirtySet;
    end

    // Register 0 is hardwired to zero and never dirty
    for (genvar i = 0; i < RegisterCount; i++) begin : genRegs
        if (i == 0) begin : genZero
            assign cellData[i] = '0;
            assign dirtyVec[i] = 1'b0;
        end else begin : genCell
            registerCell cell0 (
                .clk        (clk),
                .rstN       (rstN),
                .clkEn      (clkEn),
                .writeEn    (exDecode[i]),
                .dataIn     (exWrite.data),
                .memWriteEn (memDecode[i]),
                .memDataIn  (memWrite.data),
                .dirtySet   (dirtyDecode[i]),
                .dataOut    (cellData[i]),
                .dirtyOut   (dirtyVec[i])
            );
        end
    end

    // Read muxes
    assign readDataA = cellData[readA.addr];
    assign readDataB = cellData[readB.addr];

    // A latched port keeps stalling even if its enable drops
    assign stallA = dirtyVec[readA.addr] && (readA.en || stallLatch[0]);
    assign stallB = dirtyVec[readB.addr] && (readB.en || stallLatch[1]);
    assign stallRaw = stallA || stallB;

    // Latch follows the stall terms while stalled or on a write-back,
    // so stall drops one cycle after the clearing write-back
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stallLatch <= '0;
        end else if (clkEn && (memWrite.en || stall)) begin
            stallLatch <= {stallB, stallA};
        end
    end

    assign stall = stallRaw || (|stallLatch);

    // No loads outstanding
    assign regsSync = ~|dirtyVec;

endmodule

`default_nettype wire

// ==== verilog/loadUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadUnit #(
    parameter int LoadDepth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clkEn,
    input  regFilePkg::loadReqT  loadReq,
    output logic                 loadAccept,
    output logic                 loadFull,
    output regFilePkg::apbReqT   apbReq,
    input  regFilePkg::apbRspT   apbRsp,
    output regFilePkg::regWriteT memWrite
);
    import regFilePkg::*;

    localparam int PtrWidth = (LoadDepth > 1) ? $clog2(LoadDepth) : 1;
    localparam int CountWidth = $clog2(LoadDepth + 1);

    typedef enum logic [1:0] {
        StIdle,
        StSetup,
        StAccess
    } apbStateT;

    // Queue storage
    regAddrT destQueue [LoadDepth];
    memAddrT addrQueue [LoadDepth];

    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;

    apbStateT state;
    apbStateT stateNext;
    logic     transferDone;

    logic    wbEn;
    regAddrT wbAddr;
    dataT    wbData;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(LoadDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign loadFull = count == CountWidth'(LoadDepth);
    assign loadAccept = loadReq.valid && !loadFull && clkEn;
    assign transferDone = (state == StAccess) && apbRsp.pready;

    always_ff @(posedge clk) begin
        if (loadAccept) begin
            destQueue[wrPtr] <= loadReq.dest;
            addrQueue[wrPtr] <= loadReq.addr;
        end
    end

    // Pointers and occupancy, popped when the transfer completes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (loadAccept) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (transferDone) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({loadAccept, transferDone})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // APB requester FSM
    always_comb begin
        stateNext = state;
        case (state)
            StIdle: begin
                if (count != '0 || loadAccept) begin
                    stateNext = StSetup;
                end
            end
            StSetup: stateNext = StAccess;
            StAccess: begin
                if (apbRsp.pready) begin
                    // Entry being popped is still counted here
                    if (count > CountWidth'(1) || loadAccept) begin
                        stateNext = StSetup;
                    end else begin
                        stateNext = StIdle;
                    end
                end
            end
            default: stateNext = StIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Head of queue stays put until the pop, so paddr is stable
    assign apbReq = '{
        psel:    state != StIdle,
        penable: state == StAccess,
        pwrite:  1'b0,
        paddr:   addrQueue[rdPtr],
        pwdata:  '0
    };

    // Write-back pulse, held over cycles where the pipeline is frozen
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbEn <= 1'b0;
        end else if (transferDone) begin
            wbEn <= 1'b1;
        end else if (clkEn) begin
            wbEn <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (transferDone) begin
            wbAddr <= destQueue[rdPtr];
            wbData <= apbRsp.prdata;
        end
    end

    assign memWrite = '{addr: wbAddr, en: wbEn, data: wbData};

endmodule

`default_nettype wire

// ==== verilog/regFileTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFileTop #(
    parameter int RegisterCount = 16,
    parameter int LoadDepth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clkEn,
    input  regFilePkg::readReqT  readA,
    input  regFilePkg::readReqT  readB,
    input  regFilePkg::regWriteT exWrite,
    input  regFilePkg::loadReqT  loadReq,
    output regFilePkg::apbReqT   apbReq,
    input  regFilePkg::apbRspT   apbRsp,
    output regFilePkg::dataT     readDataA,
    output regFilePkg::dataT     readDataB,
    output logic                 stall,
    output logic                 regsSync,
    output logic                 loadFull
);
    import regFilePkg::*;

    // Between load unit and register file
    logic     loadAccept;
    regWriteT memWrite;

    registerFile #(
        .RegisterCount (RegisterCount)
    ) regFile0 (
        .clk       (clk),
        .rstN      (rstN),
        .clkEn     (clkEn),
        .readA     (readA),
        .readB     (readB),
        .exWrite   (exWrite),
        .memWrite  (memWrite),
        .dirtySet  (loadAccept),
        .dirtyAddr (loadReq.dest),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .regsSync  (regsSync),
        .stall     (stall)
    );

    loadUnit #(
        .LoadDepth (LoadDepth)
    ) loadUnit0 (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .loadReq    (loadReq),
        .loadAccept (loadAccept),
        .loadFull   (loadFull),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .memWrite   (memWrite)
    );

endmodule

`default_nettype wire

// ==== dv/apbMemModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module apbMemModel (
    input  logic               clk,
    input  logic               rstN,
    input  regFilePkg::apbReqT apbReq,
    output regFilePkg::apbRspT apbRsp
);
    import regFilePkg::*;

    integer     seed = 15234;
    logic [1:0] waitCnt;
    logic       accessDone;

    // Wait count is drawn in the setup phase
    always @(posedge clk) begin
        integer rnd;
        if (!rstN) begin
            waitCnt <= '0;
        end else if (apbReq.psel && !apbReq.penable) begin
            rnd = $random(seed);
            waitCnt <= rnd[1:0];
        end else if (apbReq.psel && apbReq.penable && waitCnt != '0) begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    assign accessDone = apbReq.psel && apbReq.penable && waitCnt == '0;

    // Memory contents are the address XOR a fixed pattern
    assign apbRsp = '{
        prdata:  accessDone ? (apbReq.paddr ^ 16'hA5C3) : '0,
        pready:  accessDone,
        pslverr: 1'b0
    };

endmodule

`default_nettype wire

// ==== dv/regFileTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFileTb;
    import regFilePkg::*;

    localparam int LoadDepth = 4;
    localparam int KStep = 0;
    localparam int KWaitStall = 1;
    localparam int KWaitSync = 2;
    localparam int KHoldLoad = 3;
    localparam int KReset = 4;
    // Expectation codes
    localparam int Model = -1;
    localparam int Skip = -2;

    typedef struct {
        int       kind;
        int       test;
        readReqT  ra;
        readReqT  rb;
        regWriteT ex;
        loadReqT  ld;
        logic     en;
        int       expA;
        int       expB;
        int       expStall;
        int       expSync;
        int       expFull;
    } stepT;

    logic clk, rstN, clkEn, stall, regsSync, loadFull;
    readReqT readA, readB;
    regWriteT exWrite;
    loadReqT loadReq;
    apbReqT apbReq;
    apbRspT apbRsp;
    dataT readDataA, readDataB;

    stepT steps[$];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 100000;

    // Reference model state
    dataT regs[16];
    logic [15:0] dirty;
    regAddrT qDest[$];
    memAddrT qAddr[$];
    logic wbPend;
    regAddrT wbDest;
    dataT wbData;

    regFileTop #(.RegisterCount(16), .LoadDepth(LoadDepth)) dut0 (
        .clk(clk), .rstN(rstN), .clkEn(clkEn), .readA(readA), .readB(readB),
        .exWrite(exWrite), .loadReq(loadReq), .apbReq(apbReq), .apbRsp(apbRsp),
        .readDataA(readDataA), .readDataB(readDataB), .stall(stall),
        .regsSync(regsSync), .loadFull(loadFull)
    );

    apbMemModel mem0 (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycles <= cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped, no progress within %0d cycles", cycleLimit);
        $display("Testbench failed");
        $finish;
    end

    task automatic checkData(input string name, input dataT got, input dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkWrite(input string name, input regWriteT got, input regWriteT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic readReqT rd(input int a, input logic e);
        return '{addr: regAddrT'(a), en: e};
    endfunction

    function automatic regWriteT wr(input int a, input logic e, input int d);
        return '{addr: regAddrT'(a), en: e, data: dataT'(d)};
    endfunction

    function automatic loadReqT ld(input logic v, input int d, input int a);
        return '{valid: v, dest: regAddrT'(d), addr: memAddrT'(a)};
    endfunction

    task automatic addStep(input int kind, input int test, input readReqT ra,
                           input readReqT rb, input regWriteT ex, input loadReqT l,
                           input logic en, input int expA, input int expB,
                           input int expStall, input int expSync, input int expFull);
        steps.push_back('{kind, test, ra, rb, ex, l, en, expA, expB,
                          expStall, expSync, expFull});
    endtask

    task automatic resetModel();
        foreach (regs[i]) regs[i] = '0;
        dirty = '0;
        qDest.delete();
        qAddr.delete();
        wbPend = 1'b0;
    endtask

    // Advances the model by one clock edge from the current inputs
    task automatic modelEdge();
        logic done;
        logic accept;
        regAddrT d;
        memAddrT a;
        regWriteT expWb;
        if (!rstN) begin
            resetModel();
            return;
        end
        // Write-back presented for the previous completion
        if (wbPend) begin
            expWb = '{addr: wbDest, en: 1'b1, data: wbData};
            checkWrite("memWrite", dut0.memWrite, expWb);
        end
        done = apbReq.psel && apbReq.penable && apbRsp.pready;
        accept = loadReq.valid && qDest.size() < LoadDepth && clkEn;
        if (clkEn) begin
            if (exWrite.en && exWrite.addr != 0) regs[exWrite.addr] = exWrite.data;
            if (wbPend) begin
                if (wbDest != 0) begin
                    regs[wbDest] = wbData;
                    dirty[wbDest] = 1'b0;
                end
                wbPend = 1'b0;
            end
        end
        if (accept) begin
            if (loadReq.dest != 0) dirty[loadReq.dest] = 1'b1;
            qDest.push_back(loadReq.dest);
            qAddr.push_back(loadReq.addr);
        end
        if (done) begin
            d = qDest.pop_front();
            a = qAddr.pop_front();
            checkData("apbReq.paddr", apbReq.paddr, a);
            wbPend = 1'b1;
            wbDest = d;
            wbData = a ^ 16'hA5C3;
        end
    endtask

    task automatic nextCycle();
        #9;
        modelEdge();
        @(negedge clk);
        #10;
    endtask

    task automatic applyStep(input stepT s, input logic afterReset);
        rstN = (s.kind != KReset);
        readA = s.ra;
        readB = s.rb;
        exWrite = s.ex;
        loadReq = s.ld;
        clkEn = s.en;
        #10;
        if (s.kind == KWaitStall) begin
            while (stall !== 1'b0) nextCycle();
        end else if (s.kind == KWaitSync) begin
            while (dirty != '0 || wbPend || qDest.size() != 0) nextCycle();
        end else if (s.kind == KHoldLoad) begin
            // Source keeps presenting the load while the queue is full
            while (qDest.size() >= LoadDepth) begin
                checkFlag("loadFull", loadFull, 1'b1);
                nextCycle();
            end
        end
        if (s.kind != KReset) begin
            if (afterReset) checkFlag("apbReq.psel", apbReq.psel, 1'b0);
            checkData("readDataA", readDataA, s.expA == Model ? regs[s.ra.addr] : dataT'(s.expA));
            checkData("readDataB", readDataB, s.expB == Model ? regs[s.rb.addr] : dataT'(s.expB));
            if (s.expStall != Skip) checkFlag("stall", stall, s.expStall[0]);
            checkFlag("regsSync", regsSync, s.expSync == Model ? dirty == '0 : s.expSync[0]);
            checkFlag("loadFull", loadFull,
                      s.expFull == Model ? qDest.size() >= LoadDepth : s.expFull[0]);
        end
        #9;
        modelEdge();
        @(negedge clk);
    endtask

    task automatic reportTest(input int test, input int errs);
        if (errs == 0) $display("test %0d: ok", test);
        else $display("test %0d: %0d errors", test, errs);
    endtask

    initial begin
        int curTest;
        int startErrors;
        logic wasReset;
        rstN = 1'b0;
        clkEn = 1'b0;
        readA = '0;
        readB = '0;
        exWrite = '0;
        loadReq = '0;
        resetModel();

        // Basic writes and reads, register 0, frozen pipeline
        addStep(KStep, 1, rd(0, 0), rd(0, 0), wr(1, 1, 'h1234), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 1, rd(1, 1), rd(0, 0), wr(2, 1, 'hBEEF), ld(0, 0, 0), 1,
                'h1234, 0, 0, 1, 0);
        addStep(KStep, 1, rd(2, 1), rd(1, 1), wr(0, 1, 'hFFFF), ld(0, 0, 0), 1,
                'hBEEF, 'h1234, 0, 1, 0);
        addStep(KStep, 1, rd(0, 1), rd(2, 1), wr(2, 1, 'h0000), ld(0, 0, 0), 0, 0, 'hBEEF, 0, 1, 0);
        addStep(KStep, 1, rd(2, 1), rd(1, 1), wr(0, 0, 0), ld(0, 0, 0), 1,
                'hBEEF, 'h1234, 0, 1, 0);
        // Single load with a stalled reader
        addStep(KStep, 2, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 3, 'h0040), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 2, rd(3, 1), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1, Model, 0, 1, 0, 0);
        addStep(KWaitStall, 2, rd(3, 1), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1,
                'hA583, 0, 0, 1, 0);
        // Back-to-back loads filling the queue
        addStep(KHoldLoad, 3, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 4, 'h0100), 1,
                0, 0, Skip, Model, Model);
        addStep(KHoldLoad, 3, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 5, 'h0102), 1,
                0, 0, Skip, 0, Model);
        addStep(KHoldLoad, 3, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 6, 'h0104), 1,
                0, 0, Skip, 0, Model);
        addStep(KHoldLoad, 3, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 7, 'h0106), 1,
                0, 0, Skip, 0, Model);
        addStep(KHoldLoad, 3, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 8, 'h0108), 1,
                0, 0, Skip, 0, Model);
        addStep(KWaitSync, 3, rd(4, 1), rd(5, 1), wr(0, 0, 0), ld(0, 0, 0), 1,
                'hA4C3, 'hA4C1, Skip, 1, 0);
        addStep(KWaitStall, 3, rd(6, 1), rd(7, 1), wr(0, 0, 0), ld(0, 0, 0), 1,
                'hA4C7, 'hA4C5, 0, 1, 0);
        addStep(KStep, 3, rd(8, 1), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1, 'hA4CB, 0, 0, 1, 0);
        // Execution write to a dirty register loses to the write-back
        addStep(KStep, 4, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 10, 'h0200), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 4, rd(1, 0), rd(11, 0), wr(10, 1, 'h1111), ld(0, 0, 0), 1,
                'h1234, 0, 0, 0, 0);
        addStep(KStep, 4, rd(10, 0), rd(2, 0), wr(0, 0, 0), ld(0, 0, 0), 1, Model, 'hBEEF, 0, 0, 0);
        addStep(KWaitSync, 4, rd(10, 1), rd(1, 1), wr(0, 0, 0), ld(0, 0, 0), 1,
                'hA7C3, 'h1234, Skip, 1, 0);
        // Load to register 0
        addStep(KStep, 5, rd(0, 1), rd(0, 0), wr(0, 0, 0), ld(1, 0, 'h0300), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 5, rd(0, 1), rd(0, 1), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 5, rd(0, 1), rd(0, 1), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 5, rd(0, 1), rd(0, 1), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        addStep(KWaitSync, 5, rd(0, 1), rd(0, 1), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        // Reset while a load is in flight
        addStep(KStep, 6, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(1, 12, 'h0400), 1, 0, 0, 0, 1, 0);
        addStep(KStep, 6, rd(12, 1), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1, Model, 0, 1, 0, 0);
        addStep(KReset, 6, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 0, 0);
        addStep(KReset, 6, rd(0, 0), rd(0, 0), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 0, 0);
        addStep(KStep, 6, rd(12, 1), rd(1, 1), wr(0, 0, 0), ld(0, 0, 0), 1, 0, 0, 0, 1, 0);
        cycleLimit = steps.size() * 8 + 100;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        curTest = -1;
        startErrors = 0;
        wasReset = 1'b0;
        foreach (steps[i]) begin
            if (steps[i].test != curTest) begin
                if (curTest >= 0) reportTest(curTest, errors - startErrors);
                curTest = steps[i].test;
                startErrors = errors;
            end
            applyStep(steps[i], wasReset);
            wasReset = (steps[i].kind == KReset);
        end
        reportTest(curTest, errors - startErrors);
        $display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/regFilePkg.sv
verilog/registerCell.sv
verilog/registerFile.sv
verilog/loadUnit.sv
verilog/regFileTop.sv
dv/apbMemModel.sv
dv/regFileTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= regFileTb
OBJ_DIR ?= obj_dir
FILE_LIST ?= compile.f
VFLAGS ?= --binary --timing
PASS_TEXT ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
